// ==== source/rob_pkg.sv ====
// Reorder buffer package
// Sizes and the packed structs shared by the allocator, the slots,
// the retire logic and the testbench

package rob_pkg;

	localparam int ROB_DEPTH = 16;	// number of buffer slots
	localparam int ROB_IDX_W = 4;	// slot index width
	localparam int PC_W = 64;
	localparam int ARN_W = 5;	// architectural register number
	localparam int PRN_W = 6;	// 64 physical registers
	localparam logic [ARN_W-1:0] ZERO_REG = 5'd31;	// shown on an idle commit port

	// one instruction from dispatch
	typedef struct packed {
		logic [PC_W-1:0]  pc;
		logic [ARN_W-1:0] arn_dest;
		logic [PRN_W-1:0] prn_dest;
		logic             is_branch;
		logic             is_uncond;
	} dispatch_t;

	// one report from a functional unit
	typedef struct packed {
		logic                 valid;
		logic [ROB_IDX_W-1:0] idx;
		logic                 mispredict;
		logic [PC_W-1:0]      target_pc;
	} complete_t;

	// state held by a single slot
	typedef struct packed {
		dispatch_t       inst;
		logic            valid;
		logic            done;	// result written back
		logic            mispredict;
		logic [PC_W-1:0] target_pc;
	} entry_t;

	// one commit port toward the rename and fetch stages
	typedef struct packed {
		logic             valid;
		logic [PC_W-1:0]  pc;
		logic [PC_W-1:0]  target_pc;
		logic             is_branch;
		logic             is_uncond;
		logic             mispredict;	// conditional branches only
		logic [ARN_W-1:0] arn_dest;
		logic [PRN_W-1:0] prn_dest;
	} commit_t;

endpackage

// ==== source/rob_entry.sv ====
// Reorder buffer slot
// Holds one instruction from dispatch until it commits or is flushed.
// Completion marks it done and records the branch outcome.

`timescale 1ns/10ps

module rob_entry (
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     load,
	input  rob_pkg::dispatch_t       load_data,
	input  logic                     complete,
	input  logic                     mispredict,
	input  logic [rob_pkg::PC_W-1:0] target_pc,
	input  logic                     clear,
	output rob_pkg::entry_t          state
);

	logic                     valid_q;
	logic                     done_q;
	logic                     mispredict_q;
	logic [rob_pkg::PC_W-1:0] target_q;
	rob_pkg::dispatch_t       inst_q;

	// occupancy and completion status
	always_ff @(posedge clock)
	begin
		if (reset || clear)	// a clear beats a load in the same cycle
		begin
			valid_q <= 1'b0;
			done_q <= 1'b0;
		end
		else if (load)
		begin
			valid_q <= 1'b1;
			done_q <= 1'b0;
		end
		else if (complete)
			done_q <= 1'b1;
	end

	always_ff @(posedge clock)
	begin
		if (load && !clear)
			inst_q <= load_data;
		if (complete)
		begin
			mispredict_q <= mispredict;
			target_q <= target_pc;	// only meaningful for branches
		end
	end

	always_comb
	begin
		state.inst = inst_q;
		state.valid = valid_q;
		state.done = done_q;
		state.mispredict = mispredict_q;
		state.target_pc = target_q;
	end

endmodule

// ==== source/rob_allocator.sv ====
// Reorder buffer allocator
// Owns the tail pointer and the occupancy count, hands out slot indices
// to dispatch and turns completion reports into per-slot strobes.
// full is raised while fewer than two slots are free.

`timescale 1ns/10ps

module rob_allocator (
	input  logic                                            clock,
	input  logic                                            reset,
	input  logic                                            load1,
	input  logic                                            load2,
	input  rob_pkg::complete_t                              complete1,
	input  rob_pkg::complete_t                              complete2,
	input  logic [rob_pkg::ROB_IDX_W-1:0]                   next_head,
	input  logic                                            flush,
	output logic [rob_pkg::ROB_IDX_W-1:0]                   idx1,
	output logic [rob_pkg::ROB_IDX_W-1:0]                   idx2,
	output logic [rob_pkg::ROB_DEPTH-1:0]                   slot_load,
	output logic [rob_pkg::ROB_DEPTH-1:0]                   slot_sel,
	output logic [rob_pkg::ROB_DEPTH-1:0]                   slot_done,
	output logic [rob_pkg::ROB_DEPTH-1:0]                   slot_mispredict,
	output logic [rob_pkg::ROB_DEPTH-1:0][rob_pkg::PC_W-1:0] slot_target,
	output logic                                            full
);

	logic [rob_pkg::ROB_IDX_W-1:0] tail_q;
	logic [rob_pkg::ROB_IDX_W-1:0] head_q;	// shadow of the retire head
	logic [rob_pkg::ROB_IDX_W:0]   count_q;	// one extra bit so 16 fits
	logic [rob_pkg::ROB_IDX_W-1:0] n_commit;
	logic [1:0]                    n_dispatch;
	logic                          take2;

	assign take2 = load1 && load2;	// load2 alone is ignored
	assign n_dispatch = take2 ? 2'd2 : {1'b0, load1};
	assign n_commit = next_head - head_q;	// 0, 1 or 2

	// indices go back to the caller in the same cycle
	assign idx1 = tail_q;
	assign idx2 = tail_q + 1'b1;

	assign full = count_q > 5'(rob_pkg::ROB_DEPTH - 2);

	// slot 1 of a pair takes dispatch2, a flush clear wins inside the slot
	always_comb
	begin
		slot_load = '0;
		slot_sel = '0;
		slot_load[idx1] = load1;
		slot_load[idx2] = slot_load[idx2] | take2;
		slot_sel[idx2] = take2;
	end

	// one-hot completion strobes
	always_comb
	begin
		slot_done = '0;
		slot_mispredict = '0;
		slot_target = '0;
		for (int i = 0; i < rob_pkg::ROB_DEPTH; i++)
		begin
			if (complete1.valid && int'(complete1.idx) == i)
			begin
				slot_done[i] = 1'b1;
				slot_mispredict[i] = complete1.mispredict;
				slot_target[i] = complete1.target_pc;
			end
			if (complete2.valid && int'(complete2.idx) == i)
			begin
				slot_done[i] = 1'b1;
				slot_mispredict[i] = complete2.mispredict;
				slot_target[i] = complete2.target_pc;
			end
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			tail_q <= '0;
			head_q <= '0;
			count_q <= '0;
		end
		else
		begin
			head_q <= next_head;
			if (flush)	// buffer empties behind the branch
			begin
				tail_q <= next_head;
				count_q <= '0;
			end
			else
			begin
				tail_q <= tail_q + n_dispatch;
				count_q <= count_q + n_dispatch - n_commit;
			end
		end
	end

endmodule

// ==== source/rob_retire.sv ====
// Reorder buffer retire logic
// Keeps the head pointer and commits up to two completed slots per
// cycle in program order. A committed mispredicted conditional branch
// flushes every younger slot.

`timescale 1ns/10ps

module rob_retire (
	input  logic                                     clock,
	input  logic                                     reset,
	input  rob_pkg::entry_t [rob_pkg::ROB_DEPTH-1:0] slots,
	output rob_pkg::commit_t                         commit1,
	output rob_pkg::commit_t                         commit2,
	output logic [rob_pkg::ROB_DEPTH-1:0]            clear,
	output logic [rob_pkg::ROB_IDX_W-1:0]            next_head,
	output logic                                     flush
);

	logic [rob_pkg::ROB_IDX_W-1:0] head_q;
	logic [rob_pkg::ROB_IDX_W-1:0] head_plus1;
	rob_pkg::entry_t               oldest;
	rob_pkg::entry_t               second;
	logic                          take1;
	logic                          take2;

	// unconditional branches never redirect at commit
	function automatic logic redirects(input rob_pkg::entry_t e);
		return e.mispredict && e.inst.is_branch && !e.inst.is_uncond;
	endfunction

	function automatic rob_pkg::commit_t make_commit(input rob_pkg::entry_t e,
		input logic take);
		rob_pkg::commit_t c;
		c = '0;
		c.arn_dest = rob_pkg::ZERO_REG;
		if (take)
		begin
			c.valid = 1'b1;
			c.pc = e.inst.pc;
			c.target_pc = e.target_pc;
			c.is_branch = e.inst.is_branch;
			c.is_uncond = e.inst.is_uncond;
			c.mispredict = redirects(e);
			c.arn_dest = e.inst.arn_dest;
			c.prn_dest = e.inst.prn_dest;
		end
		return c;
	endfunction

	assign head_plus1 = head_q + 1'b1;
	assign oldest = slots[head_q];
	assign second = slots[head_plus1];

	assign take1 = oldest.valid && oldest.done;
	// second port stops behind a redirecting branch on port 1
	assign take2 = take1 && second.valid && second.done && !redirects(oldest);

	assign flush = (take1 && redirects(oldest)) || (take2 && redirects(second));

	assign commit1 = make_commit(oldest, take1);
	assign commit2 = make_commit(second, take2);

	always_comb
	begin
		if (take2)
			next_head = head_q + 2'd2;
		else if (take1)
			next_head = head_plus1;
		else
			next_head = head_q;
	end

	// committed slots free up at the next edge, all of them on a flush
	always_comb
	begin
		clear = '0;
		if (flush)
			clear = '1;
		else
		begin
			clear[head_q] = take1;
			clear[head_plus1] = take2;
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
			head_q <= '0;
		else
			head_q <= next_head;
	end

endmodule

// ==== source/rob_top.sv ====
// Reorder buffer top level
// Dual dispatch, dual completion and dual in-order commit over a
// ring of sixteen slots. Connects the allocator, the slot array and
// the retire logic.

`timescale 1ns/10ps

module rob_top (
	input  logic                          clock,
	input  logic                          reset,
	input  logic                          load1,
	input  logic                          load2,
	input  rob_pkg::dispatch_t            dispatch1,
	input  rob_pkg::dispatch_t            dispatch2,
	input  rob_pkg::complete_t            complete1,
	input  rob_pkg::complete_t            complete2,
	output logic [rob_pkg::ROB_IDX_W-1:0] idx1,
	output logic [rob_pkg::ROB_IDX_W-1:0] idx2,
	output rob_pkg::commit_t              commit1,
	output rob_pkg::commit_t              commit2,
	output logic                          full
);

	logic [rob_pkg::ROB_DEPTH-1:0]                    slot_load;
	logic [rob_pkg::ROB_DEPTH-1:0]                    slot_sel;
	logic [rob_pkg::ROB_DEPTH-1:0]                    slot_done;
	logic [rob_pkg::ROB_DEPTH-1:0]                    slot_mispredict;
	logic [rob_pkg::ROB_DEPTH-1:0][rob_pkg::PC_W-1:0] slot_target;
	logic [rob_pkg::ROB_DEPTH-1:0]                    slot_clear;
	rob_pkg::entry_t [rob_pkg::ROB_DEPTH-1:0]         slot_state;
	logic [rob_pkg::ROB_IDX_W-1:0]                    next_head;
	logic                                             flush;

	rob_allocator allocator (
		.clock(clock),
		.reset(reset),
		.load1(load1),
		.load2(load2),
		.complete1(complete1),
		.complete2(complete2),
		.next_head(next_head),
		.flush(flush),
		.idx1(idx1),
		.idx2(idx2),
		.slot_load(slot_load),
		.slot_sel(slot_sel),
		.slot_done(slot_done),
		.slot_mispredict(slot_mispredict),
		.slot_target(slot_target),
		.full(full)
	);

	for (genvar i = 0; i < rob_pkg::ROB_DEPTH; i++)
	begin : g_slot
		rob_entry entry (
			.clock(clock),
			.reset(reset),
			.load(slot_load[i]),
			.load_data(slot_sel[i] ? dispatch2 : dispatch1),	// second of a pair
			.complete(slot_done[i]),
			.mispredict(slot_mispredict[i]),
			.target_pc(slot_target[i]),
			.clear(slot_clear[i]),
			.state(slot_state[i])
		);
	end

	rob_retire retire (
		.clock(clock),
		.reset(reset),
		.slots(slot_state),
		.commit1(commit1),
		.commit2(commit2),
		.clear(slot_clear),
		.next_head(next_head),
		.flush(flush)
	);

endmodule

// ==== bench/rob_tb.sv ====
// Reorder buffer testbench
// Directed tests for dual dispatch, out-of-order completion, in-order
// commit, the full flag and branch flush. A monitor checks every commit
// against a reference queue of dispatched instructions.

`timescale 1ns/10ps

module rob_tb;

	localparam int NUM_TESTS = 6;

	typedef struct packed {
		logic [3:0]         idx;
		rob_pkg::dispatch_t inst;
		logic               done;
		logic               mispredict;
		logic [63:0]        target;
	} ref_t;

	logic clock;
	logic reset;
	logic load1;
	logic load2;
	rob_pkg::dispatch_t dispatch1;
	rob_pkg::dispatch_t dispatch2;
	rob_pkg::complete_t complete1;
	rob_pkg::complete_t complete2;
	logic [3:0] idx1;
	logic [3:0] idx2;
	rob_pkg::commit_t commit1;
	rob_pkg::commit_t commit2;
	logic full;

	ref_t ref_q[$];	// dispatched, not yet committed
	logic [3:0] exp_tail;
	logic [31:0] lfsr;
	int error_count;
	int tests_failed;
	int commit_count;
	int pair_count;	// cycles with both ports committing
	int e0;

	rob_top uut (
		.clock(clock), .reset(reset), .load1(load1), .load2(load2),
		.dispatch1(dispatch1), .dispatch2(dispatch2),
		.complete1(complete1), .complete2(complete2),
		.idx1(idx1), .idx2(idx2), .commit1(commit1), .commit2(commit2), .full(full)
	);

	initial
	begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	// taps 32, 22, 2, 1
	function automatic logic lfsr_step();
		logic b;
		b = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], b};
		return b;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[30:0], lfsr_step()};
		return v;
	endfunction

	function automatic rob_pkg::dispatch_t make_inst(input logic br, input logic uncond);
		rob_pkg::dispatch_t d;
		logic [31:0] lo;
		logic [31:0] r;
		lo = rand_bits(32);
		d.pc = {rand_bits(32), lo[31:2], 2'b00};	// word aligned
		r = rand_bits(5);
		d.arn_dest = r[4:0];
		r = rand_bits(6);
		d.prn_dest = r[5:0];
		d.is_branch = br;
		d.is_uncond = uncond;
		return d;
	endfunction

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		assert (got == exp) else
		begin
			$display("FAIL %s: got %h expected %h", name, got, exp);
			error_count++;
		end
	endtask

	// compare one commit port with the oldest reference entry
	task automatic check_port(input rob_pkg::commit_t c, input int port);
		ref_t r;
		logic exp_mis;
		if (!c.valid)
			check_value($sformatf("commit%0d.arn_dest", port), c.arn_dest, rob_pkg::ZERO_REG);
		else
		begin
			assert (ref_q.size() != 0) else
			begin
				$display("port %0d committed pc %h with nothing outstanding", port, c.pc);
				error_count++;
			end
		end
		if (c.valid && ref_q.size() != 0)
		begin
			r = ref_q.pop_front();
			exp_mis = r.mispredict && r.inst.is_branch && !r.inst.is_uncond;
			assert (r.done) else
			begin
				$display("port %0d committed index %0d before it completed", port, r.idx);
				error_count++;
			end
			check_value($sformatf("commit%0d.pc", port), c.pc, r.inst.pc);
			check_value($sformatf("commit%0d.arn_dest", port), c.arn_dest, r.inst.arn_dest);
			check_value($sformatf("commit%0d.prn_dest", port), c.prn_dest, r.inst.prn_dest);
			check_value($sformatf("commit%0d.is_branch", port), c.is_branch, r.inst.is_branch);
			check_value($sformatf("commit%0d.is_uncond", port), c.is_uncond, r.inst.is_uncond);
			check_value($sformatf("commit%0d.mispredict", port), c.mispredict, exp_mis);
			check_value($sformatf("commit%0d.target_pc", port), c.target_pc, r.target);
			commit_count++;
			if (exp_mis)	// younger entries are gone
			begin
				ref_q.delete();
				exp_tail = r.idx + 4'd1;
			end
		end
	endtask

	// commit outputs are sampled at the edge that retires them
	always @(posedge clock)
	begin
		if (!reset)
		begin
			if (commit1.valid && commit2.valid)
				pair_count++;
			check_port(commit1, 1);
			check_port(commit2, 2);
		end
	end

	task automatic send_dispatch(input logic two, input rob_pkg::dispatch_t d1,
		input rob_pkg::dispatch_t d2);
		ref_t r;
		@(negedge clock);
		check_value("idx1", idx1, exp_tail);
		if (two)
			check_value("idx2", idx2, 4'(exp_tail + 4'd1));
		load1 = 1'b1;
		load2 = two;
		dispatch1 = d1;
		dispatch2 = d2;
		r = '0;
		r.idx = exp_tail;
		r.inst = d1;
		ref_q.push_back(r);
		if (two)
		begin
			r.idx = exp_tail + 4'd1;
			r.inst = d2;
			ref_q.push_back(r);
		end
		exp_tail = exp_tail + (two ? 4'd2 : 4'd1);
		@(negedge clock);
		load1 = 1'b0;
		load2 = 1'b0;
	endtask

	task automatic mark_done(input logic [3:0] idx, input logic mis, input logic [63:0] tgt);
		ref_t r;
		logic found;
		found = 1'b0;
		for (int i = 0; i < ref_q.size(); i++)
		begin
			if (ref_q[i].idx == idx)
			begin
				r = ref_q[i];
				r.done = 1'b1;
				r.mispredict = mis;
				r.target = tgt;
				ref_q[i] = r;
				found = 1'b1;
			end
		end
		assert (found) else
		begin
			$display("completion for index %0d matches no outstanding instruction", idx);
			error_count++;
		end
	endtask

	task automatic send_complete(input logic two, input logic [3:0] i1, input logic m1,
		input logic [63:0] t1, input logic [3:0] i2, input logic m2, input logic [63:0] t2);
		@(negedge clock);
		complete1 = '{1'b1, i1, m1, t1};
		mark_done(i1, m1, t1);
		if (two)
		begin
			complete2 = '{1'b1, i2, m2, t2};
			mark_done(i2, m2, t2);
		end
		@(negedge clock);
		complete1 = '0;
		complete2 = '0;
	endtask

	task automatic wait_commits(input int target);
		int n;
		n = 0;
		while (commit_count < target && n < 40)
		begin
			@(negedge clock);
			n++;
		end
		assert (commit_count >= target) else
		begin
			$display("expected %0d commits in total but saw %0d", target, commit_count);
			error_count++;
		end
	endtask

	task automatic test_reset();
		@(negedge clock);
		check_value("full", full, 1'b0);
		check_value("commit1.valid", commit1.valid, 1'b0);
		check_value("commit2.valid", commit2.valid, 1'b0);
		check_value("idx1", idx1, 4'd0);
	endtask

	task automatic test_out_of_order();
		int base;
		int pairs0;
		base = commit_count;
		pairs0 = pair_count;
		send_dispatch(1'b1, make_inst(1'b0, 1'b0), make_inst(1'b0, 1'b0));
		send_dispatch(1'b1, make_inst(1'b0, 1'b0), make_inst(1'b0, 1'b0));
		send_complete(1'b0, 4'd3, 1'b0, 64'h0, 4'd0, 1'b0, 64'h0);
		send_complete(1'b0, 4'd1, 1'b0, 64'h0, 4'd0, 1'b0, 64'h0);
		send_complete(1'b0, 4'd2, 1'b0, 64'h0, 4'd0, 1'b0, 64'h0);
		assert (commit_count == base) else
		begin
			$display("commits began before index 0 completed");
			error_count++;
		end
		send_complete(1'b0, 4'd0, 1'b0, 64'h0, 4'd0, 1'b0, 64'h0);
		wait_commits(base + 4);
		check_value("dual commit cycles", pair_count - pairs0, 2);
	endtask

	task automatic test_random_order();
		int order[6];
		int base;
		int j;
		int t;
		logic [3:0] start;
		base = commit_count;
		start = exp_tail;
		for (int i = 0; i < 6; i++)
		begin
			order[i] = i;
			send_dispatch(1'b0, make_inst(1'b0, 1'b0), make_inst(1'b0, 1'b0));
		end
		for (int i = 5; i > 0; i--)	// shuffle the completion order
		begin
			j = rand_bits(3) % (i + 1);
			t = order[i];
			order[i] = order[j];
			order[j] = t;
		end
		for (int i = 0; i < 6; i++)
			send_complete(1'b0, start + 4'(order[i]), 1'b0, 64'h0, 4'd0, 1'b0, 64'h0);
		wait_commits(base + 6);
		check_value("outstanding", ref_q.size(), 0);
	endtask

	task automatic test_full();
		int base;
		logic [3:0] first;
		base = commit_count;
		first = exp_tail;
		for (int i = 0; i < 7; i++)
			send_dispatch(1'b1, make_inst(1'b0, 1'b0), make_inst(1'b0, 1'b0));
		check_value("full", full, 1'b0);	// 14 in flight
		send_dispatch(1'b0, make_inst(1'b0, 1'b0), make_inst(1'b0, 1'b0));
		check_value("full", full, 1'b1);
		send_complete(1'b1, first, 1'b0, 64'h0, first + 4'd1, 1'b0, 64'h0);
		wait_commits(base + 2);
		check_value("full", full, 1'b0);
		for (int i = 2; i < 15; i++)
			send_complete(1'b0, first + 4'(i), 1'b0, 64'h0, 4'd0, 1'b0, 64'h0);
		wait_commits(base + 15);
	endtask

	task automatic test_flush();
		int base;
		logic [3:0] bi;
		base = commit_count;
		bi = exp_tail;
		send_dispatch(1'b1, make_inst(1'b1, 1'b0), make_inst(1'b0, 1'b0));
		send_dispatch(1'b1, make_inst(1'b0, 1'b0), make_inst(1'b0, 1'b0));
		send_complete(1'b1, bi + 4'd3, 1'b0, 64'h0, bi + 4'd2, 1'b0, 64'h0);
		send_complete(1'b0, bi + 4'd1, 1'b0, 64'h0, 4'd0, 1'b0, 64'h0);
		send_complete(1'b0, bi, 1'b1, 64'h0000_0000_0040_1a00, 4'd0, 1'b0, 64'h0);
		wait_commits(base + 1);
		repeat (4) @(negedge clock);	// give stray commits a chance to show
		check_value("commits", commit_count - base, 1);
		send_dispatch(1'b0, make_inst(1'b0, 1'b0), make_inst(1'b0, 1'b0));
		send_complete(1'b0, bi + 4'd1, 1'b0, 64'h0, 4'd0, 1'b0, 64'h0);
		wait_commits(base + 2);
	endtask

	task automatic test_uncond();
		int base;
		logic [3:0] ui;
		base = commit_count;
		ui = exp_tail;
		send_dispatch(1'b1, make_inst(1'b1, 1'b1), make_inst(1'b0, 1'b0));
		// younger instruction still pending when the branch commits
		send_complete(1'b0, ui, 1'b1, 64'h0000_0000_0080_0000, 4'd0, 1'b0, 64'h0);
		wait_commits(base + 1);
		send_complete(1'b0, ui + 4'd1, 1'b0, 64'h0, 4'd0, 1'b0, 64'h0);
		wait_commits(base + 2);
	endtask

	task automatic report_test(input string name, input int errors_before);
		if (error_count > errors_before)
		begin
			$display("test %s: %0d errors", name, error_count - errors_before);
			tests_failed++;
		end
		else
			$display("test %s: ok", name);
	endtask

	initial
	begin
		repeat (NUM_TESTS * 200) @(posedge clock);
		$display("watchdog expired before the tests finished");
		$display("TEST FAILED");
		$finish;
	end

	initial
	begin
		reset = 1'b1;
		load1 = 1'b0;
		load2 = 1'b0;
		dispatch1 = '0;
		dispatch2 = '0;
		complete1 = '0;
		complete2 = '0;
		exp_tail = '0;
		lfsr = 32'h6393_fe5f;
		error_count = 0;
		tests_failed = 0;
		commit_count = 0;
		pair_count = 0;
		repeat (5) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		e0 = error_count;
		test_reset();
		report_test("reset state", e0);
		e0 = error_count;
		test_out_of_order();
		report_test("out of order completion", e0);
		e0 = error_count;
		test_random_order();
		report_test("random completion order", e0);
		e0 = error_count;
		test_full();
		report_test("full flag", e0);
		e0 = error_count;
		test_flush();
		report_test("mispredict flush", e0);
		e0 = error_count;
		test_uncond();
		report_test("unconditional branch", e0);
		$display("tests run %0d, failed %0d, errors %0d", NUM_TESTS, tests_failed, error_count);
		if (error_count == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== rob_dual.f ====
source/rob_pkg.sv
source/rob_entry.sv
source/rob_allocator.sv
source/rob_retire.sv
source/rob_top.sv
bench/rob_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the reorder buffer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module rob_tb -f rob_dual.f -o rob_sim

./obj_dir/rob_sim > sim.log
cat sim.log

if grep -q "TEST PASSED" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed, see sim.log"
	exit 1
fi
